// ==== list.f ====
rtl/core_types_pkg.sv
rtl/rob_pkg.sv
rtl/rob_pointers.sv
rtl/rob_complete_match.sv
rtl/rob_entry_table.sv
rtl/rob_retire_select.sv
rtl/rob_top.sv
dv/rob_assertions.sv
dv/rob_tb.sv

// ==== dv/rob_tb.sv ====
// reorder buffer testbench
// clock, reset, reference queue model and value check
// directed tests for fill and wrap, shuffled completion, exceptions and halt

`timescale 1ns/1ps

module rob_tb;

	localparam int timeout_cycles = 2000;              // far beyond the directed tests

	typedef struct packed
	{
		core_types_pkg::preg_tag_t tag;
		core_types_pkg::arch_reg_t ar;
		logic                      ready;
		logic                      exc;
		logic                      halt;
	} model_entry_t;

	logic                                 clock;
	logic                                 reset;
	rob_pkg::rob_count_t                  dispatch_num;
	core_types_pkg::preg_tag_t            new_tag0;
	core_types_pkg::preg_tag_t            new_tag1;
	core_types_pkg::arch_reg_t            dest_ar0;
	core_types_pkg::arch_reg_t            dest_ar1;
	logic                                 valid_inst0;
	logic                                 valid_inst1;
	logic                                 halt0;
	logic                                 halt1;
	logic [core_types_pkg::cdb_width-1:0] cdb_valid;
	core_types_pkg::preg_tag_t [core_types_pkg::cdb_width-1:0] cdb_tag;
	logic [core_types_pkg::cdb_width-1:0] cdb_exc;
	rob_pkg::rob_count_t                  dispatch_cap;
	core_types_pkg::arch_reg_t            retire_ar_a;
	core_types_pkg::arch_reg_t            retire_ar_b;
	core_types_pkg::preg_tag_t            retire_tag_a;
	core_types_pkg::preg_tag_t            retire_tag_b;
	rob_pkg::rob_count_t                  retire_num;
	logic                                 retire_halt;
	logic                                 recover_exception;

	model_entry_t              model_q [$];            // oldest at the front
	int                        errors;
	int                        checks;
	int                        cycle_count;
	int                        seed;
	core_types_pkg::preg_tag_t next_tag;

	rob_top dut_i (.clock, .reset, .dispatch_num, .new_tag0, .new_tag1, .dest_ar0, .dest_ar1,
		.valid_inst0, .valid_inst1, .halt0, .halt1, .cdb_valid,
		.cdb_tag0(cdb_tag[0]), .cdb_tag1(cdb_tag[1]), .cdb_tag2(cdb_tag[2]),
		.cdb_tag3(cdb_tag[3]), .cdb_tag4(cdb_tag[4]), .cdb_tag5(cdb_tag[5]),
		.cdb_exception0(cdb_exc[0]), .cdb_exception1(cdb_exc[1]),
		.cdb_exception2(cdb_exc[2]), .cdb_exception3(cdb_exc[3]),
		.cdb_exception4(cdb_exc[4]), .cdb_exception5(cdb_exc[5]),
		.dispatch_cap, .retire_ar_a, .retire_ar_b, .retire_tag_a, .retire_tag_b,
		.retire_num, .retire_halt, .recover_exception);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("run timed out after %0d cycles without finishing the tests", cycle_count);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// checking and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAIL %0t %s actual %0h expected %0h", $time, name, actual, expected);
		end
	endtask

	function automatic int model_cap();
		if (model_q.size() >= rob_pkg::rob_depth)
			return 0;
		else if (model_q.size() == rob_pkg::rob_depth - 1)
			return 1;
		else
			return 2;
	endfunction

	function automatic core_types_pkg::preg_tag_t take_tag();
		core_types_pkg::preg_tag_t t;
		t = next_tag;
		next_tag = (next_tag == 7'd99) ? 7'd1 : next_tag + 7'd1;  // never reaches no_tag
		return t;
	endfunction

	// check this cycle's outputs and fold the driven inputs into the model
	task automatic advance();
		logic         h_ready;
		logic         n_ready;
		logic         exp_halt;
		logic         exp_recover;
		int           n_ret;
		int           n_disp;
		model_entry_t e;
		h_ready = (model_q.size() > 0) && model_q[0].ready;
		n_ready = (model_q.size() > 1) && model_q[1].ready;
		if (h_ready && n_ready && !model_q[0].exc)
			n_ret = 2;
		else if (h_ready)
			n_ret = 1;
		else
			n_ret = 0;
		exp_halt = 1'b0;
		for (int i = 0; i < n_ret; i++)
			exp_halt = exp_halt | model_q[i].halt;
		exp_recover = h_ready && (model_q[0].exc || (n_ready && model_q[1].exc));
		compare_value("dispatch_cap", dispatch_cap, model_cap());
		compare_value("retire_num", retire_num, n_ret);
		compare_value("retire_halt", retire_halt, exp_halt);
		compare_value("recover_exception", recover_exception, exp_recover);
		if (n_ret > 0)
		begin
			compare_value("retire_tag_a", retire_tag_a, model_q[0].tag);
			compare_value("retire_ar_a", retire_ar_a, model_q[0].ar);
		end
		if (n_ret > 1)
		begin
			compare_value("retire_tag_b", retire_tag_b, model_q[1].tag);
			compare_value("retire_ar_b", retire_ar_b, model_q[1].ar);
		end
		// completions see only entries already queued and the highest port applies last
		for (int p = 0; p < core_types_pkg::cdb_width; p++)
		begin
			if (cdb_valid[p])
			begin
				foreach (model_q[i])
				begin
					if (model_q[i].tag == cdb_tag[p])
					begin
						model_q[i].ready = 1'b1;
						model_q[i].exc   = cdb_exc[p];
					end
				end
			end
		end
		repeat (n_ret)
			void'(model_q.pop_front());
		n_disp = (dispatch_num == 2'd3) ? 2 : int'(dispatch_num);
		if (n_disp > 0)
		begin
			e = '{new_tag0, dest_ar0, ~valid_inst0 | halt0, 1'b0, halt0};
			model_q.push_back(e);
		end
		if (n_disp > 1)
		begin
			e = '{new_tag1, dest_ar1, ~valid_inst1 | halt1, 1'b0, halt1};
			model_q.push_back(e);
		end
		@(negedge clock);
		dispatch_num = '0;
		cdb_valid    = '0;
		cdb_exc      = '0;
	endtask

	task automatic dispatch_new(input int n, input logic v0, input logic v1,
		input logic h0, input logic h1);
		dispatch_num = rob_pkg::rob_count_t'(n);
		valid_inst0  = v0;
		valid_inst1  = v1;
		halt0        = h0;
		halt1        = h1;
		if (n > 0)
		begin
			new_tag0 = take_tag();
			dest_ar0 = new_tag0[4:0] ^ 5'h13;
		end
		if (n > 1)
		begin
			new_tag1 = take_tag();
			dest_ar1 = new_tag1[4:0] ^ 5'h13;
		end
	endtask

	task automatic drive_complete(input int port, input core_types_pkg::preg_tag_t tag,
		input logic exc);
		cdb_valid[port] = 1'b1;
		cdb_tag[port]   = tag;
		cdb_exc[port]   = exc;
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		compare_value("dispatch_cap", dispatch_cap, 2);
		compare_value("retire_num", retire_num, 0);
		compare_value("retire_halt", retire_halt, 0);
		compare_value("recover_exception", recover_exception, 0);
		advance();
	endtask

	task automatic fill_and_wrap();
		while (model_cap() != 0)
		begin
			dispatch_new(2, 1'b1, 1'b1, 1'b0, 1'b0);
			advance();
		end
		drive_complete(0, model_q[0].tag, 1'b0);      // free three head slots
		drive_complete(3, model_q[1].tag, 1'b0);
		drive_complete(4, model_q[2].tag, 1'b0);
		advance();
		while (model_q[0].ready)
			advance();
		while (model_cap() != 0)
		begin
			dispatch_new(model_cap(), 1'b1, 1'b1, 1'b0, 1'b0);  // tail wraps here
			advance();
		end
	endtask

	task automatic shuffled_completion();
		core_types_pkg::preg_tag_t pending [$];
		core_types_pkg::preg_tag_t t;
		int                        j;
		int                        burst;
		int                        port;
		foreach (model_q[i])
		begin
			if (!model_q[i].ready)
				pending.push_back(model_q[i].tag);
		end
		for (int i = pending.size() - 1; i > 0; i--)
		begin
			j          = $unsigned($random(seed)) % (i + 1);
			t          = pending[i];
			pending[i] = pending[j];
			pending[j] = t;
		end
		while (pending.size() > 0)
		begin
			burst = 1 + $unsigned($random(seed)) % 3;
			port  = $unsigned($random(seed)) % core_types_pkg::cdb_width;
			for (int b = 0; (b < burst) && (pending.size() > 0); b++)
				drive_complete((port + b) % core_types_pkg::cdb_width, pending.pop_front(), 1'b0);
			advance();
		end
		while (model_q.size() > 0)
			advance();
	endtask

	task automatic exception_recovery();
		core_types_pkg::preg_tag_t first;
		core_types_pkg::preg_tag_t second;
		dispatch_new(2, 1'b1, 1'b1, 1'b0, 1'b0);
		first  = new_tag0;
		second = new_tag1;
		advance();
		drive_complete(2, first, 1'b0);
		drive_complete(5, first, 1'b1);               // higher port carries the fault
		advance();
		advance();
		drive_complete(1, second, 1'b0);
		advance();
		while (model_q.size() > 0)
			advance();
		// fault on the younger entry while the head is clean
		dispatch_new(2, 1'b1, 1'b1, 1'b0, 1'b0);
		first  = new_tag0;
		second = new_tag1;
		advance();
		drive_complete(1, second, 1'b1);
		advance();
		advance();
		drive_complete(4, first, 1'b0);
		advance();
		while (model_q.size() > 0)
			advance();
	endtask

	task automatic no_wait_and_halt();
		dispatch_new(1, 1'b0, 1'b0, 1'b0, 1'b0);      // bubble with nothing to complete
		advance();
		advance();
		dispatch_new(2, 1'b0, 1'b1, 1'b0, 1'b1);
		advance();
		advance();
		dispatch_new(1, 1'b1, 1'b0, 1'b1, 1'b0);      // halt alone at head
		advance();
		while (model_q.size() > 0)
			advance();
		advance();
		advance();
	endtask

	initial
	begin
		seed         = 32'h2be96ddf;
		errors       = 0;
		checks       = 0;
		next_tag     = 7'd1;
		reset        = 1'b1;
		dispatch_num = '0;
		new_tag0     = '0;
		new_tag1     = '0;
		dest_ar0     = '0;
		dest_ar1     = '0;
		valid_inst0  = 1'b0;
		valid_inst1  = 1'b0;
		halt0        = 1'b0;
		halt1        = 1'b0;
		cdb_valid    = '0;
		cdb_tag      = '0;
		cdb_exc      = '0;
		repeat (16)
			@(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_reset_state();
		fill_and_wrap();
		shuffled_completion();
		exception_recovery();
		no_wait_and_halt();
		$display("checks %0d errors %0d assertion failures %0d", checks, errors,
			dut_i.assertions_i.failures);
		if ((errors == 0) && (dut_i.assertions_i.failures == 0))
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== dv/rob_assertions.sv ====
// concurrent checks on the reorder buffer top level
// dispatch within free space, lone retire of a faulting head,
// halt retire only together with a retire
// count of failed checks

`timescale 1ns/1ps

module rob_assertions
(
	input logic                clock,
	input logic                reset,
	input rob_pkg::rob_count_t dispatch_num,
	input rob_pkg::rob_count_t dispatch_cap,
	input rob_pkg::rob_count_t retire_num,
	input logic                retire_halt,
	input logic                head_exception
);

	rob_pkg::rob_count_t dispatch_count;
	int                  failures = 0;

	assign dispatch_count = (dispatch_num == 2'd3) ? 2'd2 : dispatch_num;  // 3 reads as 2

	dispatch_within_cap: assert property (@(posedge clock) disable iff (reset)
		dispatch_count <= dispatch_cap)
		else
		begin
			failures++;
			$error("dispatch of %0d with only %0d free", dispatch_count, dispatch_cap);
		end

	faulting_head_alone: assert property (@(posedge clock) disable iff (reset)
		head_exception |-> (retire_num != 2'd2))
		else
		begin
			failures++;
			$error("two entries retired past a faulting head");
		end

	halt_needs_retire: assert property (@(posedge clock) disable iff (reset)
		retire_halt |-> (retire_num != 2'd0))
		else
		begin
			failures++;
			$error("halt flagged with nothing retiring");
		end

endmodule

bind rob_top rob_assertions assertions_i (.clock, .reset, .dispatch_num, .dispatch_cap,
	.retire_num, .retire_halt, .head_exception);

// ==== rtl/rob_top.sv ====
// reorder buffer top level
// two-wide dispatch, six-port completion, two-wide in-order retire
// pointers, entry table, completion match and retire selection

`timescale 1ns/1ps

module rob_top
(
	input  logic                                 clock,
	input  logic                                 reset,
	input  rob_pkg::rob_count_t                  dispatch_num,
	input  core_types_pkg::preg_tag_t            new_tag0,
	input  core_types_pkg::preg_tag_t            new_tag1,
	input  core_types_pkg::arch_reg_t            dest_ar0,
	input  core_types_pkg::arch_reg_t            dest_ar1,
	input  logic                                 valid_inst0,
	input  logic                                 valid_inst1,
	input  logic                                 halt0,
	input  logic                                 halt1,
	input  logic [core_types_pkg::cdb_width-1:0] cdb_valid,
	input  core_types_pkg::preg_tag_t            cdb_tag0,
	input  core_types_pkg::preg_tag_t            cdb_tag1,
	input  core_types_pkg::preg_tag_t            cdb_tag2,
	input  core_types_pkg::preg_tag_t            cdb_tag3,
	input  core_types_pkg::preg_tag_t            cdb_tag4,
	input  core_types_pkg::preg_tag_t            cdb_tag5,
	input  logic                                 cdb_exception0,
	input  logic                                 cdb_exception1,
	input  logic                                 cdb_exception2,
	input  logic                                 cdb_exception3,
	input  logic                                 cdb_exception4,
	input  logic                                 cdb_exception5,
	output rob_pkg::rob_count_t                  dispatch_cap,
	output core_types_pkg::arch_reg_t            retire_ar_a,
	output core_types_pkg::arch_reg_t            retire_ar_b,
	output core_types_pkg::preg_tag_t            retire_tag_a,
	output core_types_pkg::preg_tag_t            retire_tag_b,
	output rob_pkg::rob_count_t                  retire_num,
	output logic                                 retire_halt,
	output logic                                 recover_exception
);

	rob_pkg::rob_idx_t         head;
	rob_pkg::rob_idx_t         head_plus_one;
	rob_pkg::rob_idx_t         tail;
	rob_pkg::rob_idx_t         tail_plus_one;
	logic                      head_valid;
	rob_pkg::rob_vec_t         entry_valid;
	core_types_pkg::preg_tag_t entry_tag [rob_pkg::rob_depth];
	rob_pkg::rob_vec_t         complete_hit;
	rob_pkg::rob_vec_t         complete_exc;
	logic                      head_ready;
	logic                      next_ready;
	logic                      head_exception;
	logic                      next_exception;
	logic                      head_halt;
	logic                      next_halt;

	rob_pointers pointers_i (.clock, .reset, .dispatch_num, .retire_num, .head_valid,
		.head, .head_plus_one, .tail, .tail_plus_one, .dispatch_cap);

	rob_complete_match match_i (.cdb_valid, .cdb_tag0, .cdb_tag1, .cdb_tag2, .cdb_tag3,
		.cdb_tag4, .cdb_tag5, .cdb_exception0, .cdb_exception1, .cdb_exception2,
		.cdb_exception3, .cdb_exception4, .cdb_exception5, .entry_valid, .entry_tag,
		.complete_hit, .complete_exc);

	rob_entry_table table_i (.clock, .reset, .tail, .tail_plus_one, .head, .head_plus_one,
		.dispatch_num, .retire_num, .new_tag0, .new_tag1, .dest_ar0, .dest_ar1,
		.valid_inst0, .valid_inst1, .halt0, .halt1, .complete_hit, .complete_exc,
		.entry_valid, .entry_tag, .head_valid, .head_ready, .next_ready,
		.head_exception, .next_exception, .head_halt, .next_halt,
		.retire_ar_a, .retire_ar_b, .retire_tag_a, .retire_tag_b);

	// combinational from registered head state, feeds back into pointers and table
	rob_retire_select select_i (.head_ready, .next_ready, .head_exception,
		.next_exception, .head_halt, .next_halt, .retire_num, .retire_halt,
		.recover_exception);

endmodule

// ==== rtl/rob_retire_select.sv ====
// in-order retire selection
// retire count from the two head entries
// halt retire and exception recovery flags

`timescale 1ns/1ps

module rob_retire_select
(
	input  logic                head_ready,
	input  logic                next_ready,
	input  logic                head_exception,
	input  logic                next_exception,
	input  logic                head_halt,
	input  logic                next_halt,
	output rob_pkg::rob_count_t retire_num,
	output logic                retire_halt,
	output logic                recover_exception
);

	logic retire_two;
	logic retire_one;

	//////////////////////////////////////////////////////////////////////
	// retire count
	//////////////////////////////////////////////////////////////////////

	// a faulting head retires alone so nothing younger commits past it
	assign retire_two = head_ready & next_ready & ~head_exception;
	assign retire_one = head_ready & ~retire_two;

	always_comb
	begin
		if (retire_two)
			retire_num = 2'd2;
		else if (retire_one)
			retire_num = 2'd1;
		else
			retire_num = 2'd0;
	end

	//////////////////////////////////////////////////////////////////////
	// flags
	//////////////////////////////////////////////////////////////////////

	assign retire_halt = (head_ready & head_halt) |     // head goes in either case
		(retire_two & next_halt);

	assign recover_exception = head_ready &
		(head_exception | (next_ready & next_exception));

endmodule

// ==== rtl/rob_entry_table.sv ====
// reorder buffer entry storage
// per-entry valid, ready, exception, halt, destination and tag
// dispatch writes, completion updates and retire clears
// head and next-entry status for retire selection

`timescale 1ns/1ps

module rob_entry_table
(
	input  logic                      clock,
	input  logic                      reset,
	input  rob_pkg::rob_idx_t         tail,
	input  rob_pkg::rob_idx_t         tail_plus_one,
	input  rob_pkg::rob_idx_t         head,
	input  rob_pkg::rob_idx_t         head_plus_one,
	input  rob_pkg::rob_count_t       dispatch_num,
	input  rob_pkg::rob_count_t       retire_num,
	input  core_types_pkg::preg_tag_t new_tag0,
	input  core_types_pkg::preg_tag_t new_tag1,
	input  core_types_pkg::arch_reg_t dest_ar0,
	input  core_types_pkg::arch_reg_t dest_ar1,
	input  logic                      valid_inst0,
	input  logic                      valid_inst1,
	input  logic                      halt0,
	input  logic                      halt1,
	input  rob_pkg::rob_vec_t         complete_hit,
	input  rob_pkg::rob_vec_t         complete_exc,
	output rob_pkg::rob_vec_t         entry_valid,
	output core_types_pkg::preg_tag_t entry_tag [rob_pkg::rob_depth],
	output logic                      head_valid,
	output logic                      head_ready,
	output logic                      next_ready,
	output logic                      head_exception,
	output logic                      next_exception,
	output logic                      head_halt,
	output logic                      next_halt,
	output core_types_pkg::arch_reg_t retire_ar_a,
	output core_types_pkg::arch_reg_t retire_ar_b,
	output core_types_pkg::preg_tag_t retire_tag_a,
	output core_types_pkg::preg_tag_t retire_tag_b
);

	rob_pkg::rob_vec_t         valid;
	rob_pkg::rob_vec_t         ready;
	rob_pkg::rob_vec_t         exception;
	rob_pkg::rob_vec_t         halt;
	core_types_pkg::arch_reg_t ar  [rob_pkg::rob_depth];
	core_types_pkg::preg_tag_t tag [rob_pkg::rob_depth];

	rob_pkg::rob_vec_t         disp_sel0;              // slot 0 lands here
	rob_pkg::rob_vec_t         disp_sel1;              // slot 1 lands here
	rob_pkg::rob_vec_t         ret_sel;                // cleared by retire

	//////////////////////////////////////////////////////////////////////
	// slot decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < rob_pkg::rob_depth; i++)
		begin
			disp_sel0[i] = (dispatch_num != 2'd0) && (tail == rob_pkg::rob_idx_t'(i));
			disp_sel1[i] = dispatch_num[1] && (tail_plus_one == rob_pkg::rob_idx_t'(i));
			ret_sel[i]   = ((retire_num != 2'd0) && (head == rob_pkg::rob_idx_t'(i))) ||
				(retire_num[1] && (head_plus_one == rob_pkg::rob_idx_t'(i)));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// entry state, later updates win
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid     <= '0;
			ready     <= '0;
			exception <= '0;
			halt      <= '0;
			for (int i = 0; i < rob_pkg::rob_depth; i++)
				tag[i] <= core_types_pkg::no_tag;
		end
		else
		begin
			for (int i = 0; i < rob_pkg::rob_depth; i++)
			begin
				if (disp_sel0[i])
				begin
					valid[i]     <= 1'b1;
					ready[i]     <= ~valid_inst0 | halt0;  // nothing to wait for
					exception[i] <= 1'b0;
					halt[i]      <= halt0;
					tag[i]       <= new_tag0;
				end
				if (disp_sel1[i])
				begin
					valid[i]     <= 1'b1;
					ready[i]     <= ~valid_inst1 | halt1;
					exception[i] <= 1'b0;
					halt[i]      <= halt1;
					tag[i]       <= new_tag1;
				end
				if (complete_hit[i])
				begin
					ready[i]     <= 1'b1;
					exception[i] <= complete_exc[i];
				end
				if (ret_sel[i])
				begin
					valid[i] <= 1'b0;
					ready[i] <= 1'b0;
					halt[i]  <= 1'b0;
					tag[i]   <= core_types_pkg::no_tag;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < rob_pkg::rob_depth; i++)
		begin
			if (disp_sel0[i])
				ar[i] <= dest_ar0;
			if (disp_sel1[i])
				ar[i] <= dest_ar1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read ports
	//////////////////////////////////////////////////////////////////////

	assign entry_valid = valid;
	assign entry_tag   = tag;

	assign head_valid     = valid[head];
	assign head_ready     = ready[head];
	assign next_ready     = ready[head_plus_one];
	assign head_exception = exception[head];
	assign next_exception = exception[head_plus_one];
	assign head_halt      = halt[head];
	assign next_halt      = halt[head_plus_one];

	assign retire_ar_a  = ar[head];                      // to map table
	assign retire_ar_b  = ar[head_plus_one];
	assign retire_tag_a = tag[head];                     // to map table and free list
	assign retire_tag_b = tag[head_plus_one];

endmodule

// ==== rtl/rob_complete_match.sv ====
// completion bus tag match
// compares every active broadcast tag against every valid entry
// per-entry set-ready vector and exception flag vector

`timescale 1ns/1ps

module rob_complete_match
(
	input  logic [core_types_pkg::cdb_width-1:0] cdb_valid,
	input  core_types_pkg::preg_tag_t            cdb_tag0,
	input  core_types_pkg::preg_tag_t            cdb_tag1,
	input  core_types_pkg::preg_tag_t            cdb_tag2,
	input  core_types_pkg::preg_tag_t            cdb_tag3,
	input  core_types_pkg::preg_tag_t            cdb_tag4,
	input  core_types_pkg::preg_tag_t            cdb_tag5,
	input  logic                                 cdb_exception0,
	input  logic                                 cdb_exception1,
	input  logic                                 cdb_exception2,
	input  logic                                 cdb_exception3,
	input  logic                                 cdb_exception4,
	input  logic                                 cdb_exception5,
	input  rob_pkg::rob_vec_t                    entry_valid,
	input  core_types_pkg::preg_tag_t            entry_tag [rob_pkg::rob_depth],
	output rob_pkg::rob_vec_t                    complete_hit,
	output rob_pkg::rob_vec_t                    complete_exc
);

	core_types_pkg::preg_tag_t            cdb_tag [core_types_pkg::cdb_width];
	logic [core_types_pkg::cdb_width-1:0] cdb_exc;

	// gather the loose ports so the compare can loop
	assign cdb_tag[0] = cdb_tag0;
	assign cdb_tag[1] = cdb_tag1;
	assign cdb_tag[2] = cdb_tag2;
	assign cdb_tag[3] = cdb_tag3;
	assign cdb_tag[4] = cdb_tag4;
	assign cdb_tag[5] = cdb_tag5;

	assign cdb_exc = {cdb_exception5, cdb_exception4, cdb_exception3,
		cdb_exception2, cdb_exception1, cdb_exception0};

	//////////////////////////////////////////////////////////////////////
	// entry by port compare
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		complete_hit = '0;
		complete_exc = '0;
		for (int e = 0; e < rob_pkg::rob_depth; e++)
		begin
			// ascending port order, so the highest matching port sets the flag
			for (int p = 0; p < core_types_pkg::cdb_width; p++)
			begin
				if (cdb_valid[p] && entry_valid[e] && (cdb_tag[p] == entry_tag[e]))
				begin
					complete_hit[e] = 1'b1;
					complete_exc[e] = cdb_exc[p];
				end
			end
		end
	end

endmodule

// ==== rtl/rob_pointers.sv ====
// reorder buffer head and tail pointers
// wrap arithmetic for dispatch and retire advances
// free-space count reported back to dispatch

`timescale 1ns/1ps

module rob_pointers
(
	input  logic                clock,
	input  logic                reset,
	input  rob_pkg::rob_count_t dispatch_num,
	input  rob_pkg::rob_count_t retire_num,
	input  logic                head_valid,
	output rob_pkg::rob_idx_t   head,
	output rob_pkg::rob_idx_t   head_plus_one,
	output rob_pkg::rob_idx_t   tail,
	output rob_pkg::rob_idx_t   tail_plus_one,
	output rob_pkg::rob_count_t dispatch_cap
);

	localparam int idx_w = $bits(rob_pkg::rob_idx_t);
	localparam logic [idx_w:0] depth_ext = (idx_w + 1)'(rob_pkg::rob_depth);

	rob_pkg::rob_count_t dispatch_count;                // 3 folded to 2
	logic                full;
	logic                one_free;

	// position plus a small count, wrapping at the queue depth
	function automatic rob_pkg::rob_idx_t wrap_add
	(
		input rob_pkg::rob_idx_t   idx,
		input rob_pkg::rob_count_t n
	);
		logic [idx_w:0] sum;
		sum = {1'b0, idx} + {{(idx_w - 1){1'b0}}, n};
		if (sum >= depth_ext)
			sum = sum - depth_ext;
		return sum[idx_w-1:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// pointer registers
	//////////////////////////////////////////////////////////////////////

	assign dispatch_count = (dispatch_num == 2'd3) ? 2'd2 : dispatch_num;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
		end
		else
		begin
			head <= wrap_add(head, retire_num);
			tail <= wrap_add(tail, dispatch_count);
		end
	end

	assign head_plus_one = wrap_add(head, 2'd1);
	assign tail_plus_one = wrap_add(tail, 2'd1);

	//////////////////////////////////////////////////////////////////////
	// capacity
	//////////////////////////////////////////////////////////////////////

	assign full     = (head == tail) && head_valid;     // equal pointers, occupied head
	assign one_free = (tail_plus_one == head);          // a single gap before head

	assign dispatch_cap = full ? 2'd0 : (one_free ? 2'd1 : 2'd2);

endmodule

// ==== rtl/rob_pkg.sv ====
// reorder buffer sizing
// queue depth, position index, instruction count and per-entry vector

package rob_pkg;

	//////////////////////////////////////////////////////////////////////
	// queue geometry
	//////////////////////////////////////////////////////////////////////

	localparam int rob_depth = 16;                     // entries in the circular queue
	localparam int rob_idx_w = $clog2(rob_depth);      // bits per queue position

	//////////////////////////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////////////////////////

	typedef logic [rob_idx_w-1:0] rob_idx_t;           // head or tail position

	// counts of 0 to 2 for dispatch, capacity and retire
	// a dispatch count of 3 is read as 2
	typedef logic [1:0] rob_count_t;

	typedef logic [rob_depth-1:0] rob_vec_t;           // one bit per entry

endpackage

// ==== rtl/core_types_pkg.sv ====
// core-wide register naming types
// physical tag and architectural register index vectors
// completion bus port count and empty-slot tag value

package core_types_pkg;

	//////////////////////////////////////////////////////////////////////
	// register naming
	//////////////////////////////////////////////////////////////////////

	typedef logic [6:0] preg_tag_t;                    // physical register tag
	typedef logic [4:0] arch_reg_t;                    // architectural register index

	//////////////////////////////////////////////////////////////////////
	// completion bus
	//////////////////////////////////////////////////////////////////////

	localparam int cdb_width = 6;                      // broadcast ports per cycle

	// an empty slot holds this tag so a stray broadcast cannot match it
	localparam preg_tag_t no_tag = '1;

endpackage
